//--- sources.f
kicker_pkg.sv
kicker_cabinet.sv
kicker_irq.sv
psg_tone.sv
kicker_mixer.sv
kicker_decode.sv
kicker_main.sv
tb_kicker_main.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator, pass only if the log says so
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
    --top-module tb_kicker_main -f sources.f -o sim_kicker

./obj_dir/sim_kicker > sim.log
cat sim.log

grep -q "ALL CHECKS PASSED" sim.log
echo "simulation passed"

//--- tb_kicker_main.sv
`timescale 1ns/1ps

module tb_kicker_main import kicker_pkg::*; ();

    localparam int clk_period   = 100;
    localparam int reset_cycles = 10;
    localparam int n_cycles     = 4000;

    logic               clk;
    logic               rst;
    bus_req_t           bus;
    logic               psg1_cen;
    logic               psg2_cen;
    logic               lvbl;
    logic               dip_pause;
    logic [7:0]         dipsw_b;
    logic [3:0]         dipsw_c;
    logic [1:0]         start_button;
    logic [1:0]         coin_input;
    logic [5:0]         joystick1;
    logic [5:0]         joystick2;
    logic               service;
    logic [7:0]         rd_data;
    logic               rd_valid;
    gfx_wr_t            gfx_wr;
    logic               flip;
    logic [2:0]         pal_sel;
    logic               irq_n;
    logic signed [15:0] snd;
    logic               peak;

    // Model state, mirrors what the board should hold after each edge
    logic               m_rd_valid;
    logic [7:0]         m_rd_data;
    gfx_wr_t            m_gfx;
    logic               m_flip;
    logic [2:0]         m_pal;
    logic               m_irq_en;
    logic               m_irq_n;
    logic               m_lvbl_d;
    logic [7:0]         m_psg_data [2];
    logic               m_psg_wr [2];
    logic [2:0]         m_reg_sel [2];
    logic [9:0]         m_period [2];
    logic [3:0]         m_atten [2];
    logic [9:0]         m_cnt [2];
    logic               m_phase [2];
    logic signed [10:0] m_sound [2];
    logic signed [15:0] m_snd;
    logic               m_peak;

    int errors;
    int checks;
    int n_irq;
    int n_gfx;
    int n_rd;
    int n_snd;

    kicker_main kicker_main_i (
        .clk, .rst, .bus, .psg1_cen, .psg2_cen, .lvbl, .dip_pause, .dipsw_b, .dipsw_c,
        .start_button, .coin_input, .joystick1, .joystick2, .service,
        .rd_data, .rd_valid, .gfx_wr, .flip, .pal_sel, .irq_n, .snd, .peak
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("mismatch at %0d ns: %s = %h, expected %h", $time, name, got, exp);
        end
    endtask

    // Up/down and left/right pairs are crossed on the board
    function automatic logic [7:0] joy_read(input logic [5:0] j);
        return {2'b11, j[5], j[4], j[2], j[3], j[0], j[1]};
    endfunction

    function automatic logic [7:0] read_byte(input logic [15:0] a);
        logic [7:0] v;
        v = 8'hff;                                  // Unmapped and video reads
        if (a[13:11] == region_sys) begin
            case (a[10:8])
                sys_dip_b:  v = dipsw_b;
                sys_dip_c:  v = {4'hf, dipsw_c};
                sys_inputs: begin
                    case (a[1:0])
                        2'd0:    v = {4'hf, dipsw_c};
                        2'd1:    v = joy_read(joystick2);
                        2'd2:    v = joy_read(joystick1);
                        default: v = {3'b111, start_button, service, coin_input};
                    endcase
                end
                default: v = 8'hff;
            endcase
        end
        return v;
    endfunction

    function automatic logic [7:0] psg_byte();
        case ($urandom % 4)
            0:       return {1'b1, 3'd0, 4'($urandom)};  // Period low nibble
            1:       return {1'b1, 3'd1, 4'($urandom)};  // Attenuation
            2:       return {2'b00, 6'($urandom % 3)};   // Short period
            default: return 8'($urandom);
        endcase
    endfunction

    task automatic model_reset();
        m_rd_valid = 1'b0;
        m_rd_data  = 8'hff;
        m_gfx      = '0;
        m_flip     = 1'b0;
        m_pal      = 3'd0;
        m_irq_en   = 1'b0;
        m_irq_n    = 1'b1;
        m_lvbl_d   = 1'b0;
        m_snd      = 16'sd0;
        m_peak     = 1'b0;
        for (int i = 0; i < 2; i++) begin
            m_psg_data[i] = 8'd0;
            m_psg_wr[i]   = 1'b0;
            m_reg_sel[i]  = 3'd0;
            m_period[i]   = 10'd0;
            m_atten[i]    = 4'hf;
            m_cnt[i]      = 10'd0;
            m_phase[i]    = 1'b0;
            m_sound[i]    = 11'sd0;
        end
    endtask

    // One clock edge of the board, every stage reads last cycle's state
    task automatic model_edge();
        int         acc;
        logic       cen;
        logic [9:0] amp;
        logic [7:0] din;
        logic       wr;
        logic       rd;
        logic [2:0] region;
        logic [2:0] sub;
        logic       obj;
        acc = (int'(m_sound[0]) * int'(mix_gain0) + int'(m_sound[1]) * int'(mix_gain1)) >>> 4;
        m_peak = (acc > 32767) || (acc < -32768);
        if (acc > 32767) m_snd = 16'sh7fff;
        else if (acc < -32768) m_snd = 16'h8000;
        else m_snd = 16'(acc);

        for (int i = 0; i < 2; i++) begin
            cen = (i == 0) ? psg1_cen : psg2_cen;
            if (cen) begin
                amp = psg_atten_table[m_atten[i]];
                if (m_cnt[i] == 10'd0 || m_cnt[i] == 10'd1) begin
                    m_cnt[i]   = m_period[i];       // Count hits zero
                    m_phase[i] = ~m_phase[i];
                end else begin
                    m_cnt[i] = m_cnt[i] - 10'd1;
                end
                m_sound[i] = {1'b0, amp};
                if (!m_phase[i]) m_sound[i] = -m_sound[i];
            end
            if (m_psg_wr[i]) begin
                din = m_psg_data[i];
                if (din[7]) begin
                    m_reg_sel[i] = din[6:4];
                    if (din[6:4] == 3'd0) m_period[i][3:0] = din[3:0];
                    else if (din[6:4] == 3'd1) m_atten[i] = din[3:0];
                end else if (m_reg_sel[i] == 3'd0) begin
                    m_period[i][9:4] = din[5:0];
                end
            end
        end

        if (!m_irq_en) m_irq_n = 1'b1;
        else if (m_lvbl_d && !lvbl && dip_pause) m_irq_n = 1'b0;
        m_lvbl_d = lvbl;

        wr     = bus.strobe && bus.we;
        rd     = bus.strobe && !bus.we;
        region = bus.addr[13:11];
        sub    = bus.addr[10:8];
        obj    = (region == region_obj_lo) || (region == region_obj_hi);
        m_rd_valid = rd;
        if (rd) m_rd_data = read_byte(bus.addr);
        m_gfx.strobe = wr && (obj || region == region_vram);
        m_gfx.obj    = obj;
        m_gfx.addr   = obj ? {bus.addr[11], bus.addr[9:0]} : bus.addr[10:0];
        m_gfx.data   = bus.wdata;
        m_psg_wr[0]  = wr && region == region_sys && sub == sys_psg1;
        m_psg_wr[1]  = wr && region == region_sys && sub == sys_psg2;
        if (wr && region == region_sys && sub == sys_ctrl) begin
            m_flip   = bus.wdata[0];
            m_irq_en = bus.wdata[2];
        end
        if (wr && region == region_color) m_pal = bus.wdata[2:0];
        if (wr && region == region_snd1) m_psg_data[0] = bus.wdata;
        if (wr && region == region_snd2) m_psg_data[1] = bus.wdata;
    endtask

    task automatic check_outputs();
        check("rd_valid", 32'(rd_valid), 32'(m_rd_valid));
        if (m_rd_valid) check("rd_data", 32'(rd_data), 32'(m_rd_data));
        check("gfx_wr.strobe", 32'(gfx_wr.strobe), 32'(m_gfx.strobe));
        if (m_gfx.strobe) begin
            check("gfx_wr.obj", 32'(gfx_wr.obj), 32'(m_gfx.obj));
            check("gfx_wr.addr", 32'(gfx_wr.addr), 32'(m_gfx.addr));
            check("gfx_wr.data", 32'(gfx_wr.data), 32'(m_gfx.data));
        end
        check("flip", 32'(flip), 32'(m_flip));
        check("pal_sel", 32'(pal_sel), 32'(m_pal));
        check("irq_n", 32'(irq_n), 32'(m_irq_n));
        check("snd", 32'(snd), 32'(m_snd));
        check("peak", 32'(peak), 32'(m_peak));
    endtask

    task automatic drive_random();
        logic [15:0] a;
        a          = 16'($urandom);
        bus.strobe = 1'b1;
        bus.we     = 1'b1;
        bus.wdata  = 8'($urandom);
        case ($urandom % 12)
            0, 1: bus.strobe = 1'b0;
            2: begin                                 // Cabinet and DIP reads
                bus.we    = 1'b0;
                a[13:11]  = region_sys;
                case ($urandom % 3)
                    0:       a[10:8] = sys_dip_b;
                    1:       a[10:8] = sys_dip_c;
                    default: a[10:8] = sys_inputs;
                endcase
            end
            3: bus.we = 1'b0;                        // Anywhere, mostly unmapped
            4: a[13:11] = 3'(5 + $urandom % 3);      // Object or video RAM
            5: a[13:8] = {region_sys, sys_ctrl};
            6: a[13:11] = region_color;
            7, 8: begin
                a[13:11]  = ($urandom % 2 == 0) ? region_snd1 : region_snd2;
                bus.wdata = psg_byte();
            end
            9: a[13:8] = {region_sys, ($urandom % 2 == 0) ? sys_psg1 : sys_psg2};
            10: ;                                    // Random write
            default: begin
                bus.we   = 1'b0;
                a[13:11] = region_sys;
            end
        endcase
        bus.addr     = a;
        psg1_cen     = ($urandom % 4) == 0;
        psg2_cen     = ($urandom % 4) == 0;
        if ($urandom % 6 == 0) lvbl = ~lvbl;
        if ($urandom % 50 == 0) dip_pause = ~dip_pause;
        dipsw_b      = 8'($urandom);
        dipsw_c      = 4'($urandom);
        start_button = 2'($urandom);
        coin_input   = 2'($urandom);
        joystick1    = 6'($urandom);
        joystick2    = 6'($urandom);
        service      = 1'($urandom);
    endtask

    initial begin
        errors = 0;
        checks = 0;
        n_irq  = 0;
        n_gfx  = 0;
        n_rd   = 0;
        n_snd  = 0;
        void'($urandom(32'h8e73));
        clk          = 1'b0;
        rst          = 1'b1;
        bus          = '0;
        psg1_cen     = 1'b0;
        psg2_cen     = 1'b0;
        lvbl         = 1'b1;
        dip_pause    = 1'b1;
        dipsw_b      = 8'd0;
        dipsw_c      = 4'd0;
        start_button = 2'd0;
        coin_input   = 2'd0;
        joystick1    = 6'd0;
        joystick2    = 6'd0;
        service      = 1'b0;
        model_reset();
        repeat (reset_cycles) @(posedge clk);
        #1;
        check_outputs();                             // Reset values
        rst = 1'b0;
        for (int c = 0; c < n_cycles; c++) begin
            @(posedge clk);
            #1;
            model_edge();
            check_outputs();
            if (!irq_n) n_irq++;
            if (gfx_wr.strobe) n_gfx++;
            if (rd_valid) n_rd++;
            if (snd != 16'sd0) n_snd++;
            drive_random();
        end
        if (n_irq == 0 || n_gfx == 0 || n_rd == 0 || n_snd == 0) begin
            errors++;
            $display("Stimulus gap: no interrupt, video write, read or sound was seen");
        end
        $display("errors: %0d in %0d checks", errors, checks);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Run length plus margin
    initial begin
        #((n_cycles + reset_cycles + 50) * clk_period);
        $display("Timeout: simulation ran past its cycle budget");
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

//--- kicker_main.sv
`timescale 1ns/1ps

module kicker_main import kicker_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  bus_req_t           bus,
    input  logic               psg1_cen,
    input  logic               psg2_cen,
    input  logic               lvbl,
    input  logic               dip_pause,
    input  logic [7:0]         dipsw_b,
    input  logic [3:0]         dipsw_c,
    input  logic [1:0]         start_button,
    input  logic [1:0]         coin_input,
    input  logic [5:0]         joystick1,
    input  logic [5:0]         joystick2,
    input  logic               service,
    output logic [7:0]         rd_data,
    output logic               rd_valid,
    output gfx_wr_t            gfx_wr,
    output logic               flip,
    output logic [2:0]         pal_sel,
    output logic               irq_n,
    output logic signed [15:0] snd,
    output logic               peak
);
    logic [1:0]         cab_sel;
    logic [7:0]         cab_byte;
    logic               irq_en;
    logic [7:0]         psg1_data;
    logic [7:0]         psg2_data;
    logic               psg1_wr;
    logic               psg2_wr;
    logic signed [10:0] psg1_snd;
    logic signed [10:0] psg2_snd;

    kicker_decode decode (
        .clk, .rst, .bus,
        .cabinet  (cab_byte),
        .dipsw_b,
        .cab_sel, .rd_data, .rd_valid, .gfx_wr, .flip, .pal_sel, .irq_en,
        .psg1_data, .psg1_wr, .psg2_data, .psg2_wr
    );

    kicker_cabinet cabinet (
        .cab_sel, .start_button, .coin_input, .joystick1, .joystick2,
        .service, .dipsw_c,
        .cabinet  (cab_byte)
    );

    kicker_irq irq (.clk, .rst, .lvbl, .dip_pause, .irq_en, .irq_n);

    // One tone voice per sound chip
    psg_tone psg1 (
        .clk, .rst, .psg_cen (psg1_cen), .wr (psg1_wr), .din (psg1_data), .sound (psg1_snd)
    );

    psg_tone psg2 (
        .clk, .rst, .psg_cen (psg2_cen), .wr (psg2_wr), .din (psg2_data), .sound (psg2_snd)
    );

    kicker_mixer #(.gain0(mix_gain0), .gain1(mix_gain1)) mixer (
        .clk, .rst, .ch0 (psg1_snd), .ch1 (psg2_snd), .snd, .peak
    );

endmodule

//--- kicker_decode.sv
`timescale 1ns/1ps

module kicker_decode import kicker_pkg::*; (
    input  logic       clk,
    input  logic       rst,
    input  bus_req_t   bus,
    input  logic [7:0] cabinet,
    input  logic [7:0] dipsw_b,
    output logic [1:0] cab_sel,
    output logic [7:0] rd_data,
    output logic       rd_valid,
    output gfx_wr_t    gfx_wr,
    output logic       flip,
    output logic [2:0] pal_sel,
    output logic       irq_en,
    output logic [7:0] psg1_data,
    output logic       psg1_wr,
    output logic [7:0] psg2_data,
    output logic       psg2_wr
);
    logic [2:0] region;
    logic [2:0] sub;
    logic       wr;
    logic       rd;
    logic       sys_cs;
    logic       vram_cs;
    logic       obj_cs;
    logic [7:0] rd_mux;

    assign region  = bus.addr[13:11];   // A15 and A14 ignored
    assign sub     = bus.addr[10:8];
    assign wr      = bus.strobe & bus.we;
    assign rd      = bus.strobe & ~bus.we;
    assign sys_cs  = region == region_sys;
    assign vram_cs = region == region_vram;
    assign obj_cs  = (region == region_obj_lo) || (region == region_obj_hi);

    // DIP C reads share cabinet byte 0
    assign cab_sel = (sys_cs && sub == sys_dip_c) ? 2'd0 : bus.addr[1:0];

    always_comb begin
        rd_mux = 8'hff;
        case (region)
            region_sys: begin
                case (sub)
                    sys_dip_b:             rd_mux = dipsw_b;
                    sys_dip_c, sys_inputs: rd_mux = cabinet;
                    default:               rd_mux = 8'hff;
                endcase
            end
            default: rd_mux = 8'hff;    // Video memory reads are not returned
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rd_valid  <= 1'b0;
            gfx_wr    <= '0;
            flip      <= 1'b0;
            pal_sel   <= 3'd0;
            irq_en    <= 1'b0;
            psg1_data <= 8'd0;
            psg2_data <= 8'd0;
            psg1_wr   <= 1'b0;
            psg2_wr   <= 1'b0;
        end else begin
            rd_valid      <= rd;
            gfx_wr.strobe <= wr & (vram_cs | obj_cs);
            gfx_wr.obj    <= obj_cs;
            gfx_wr.addr   <= obj_cs ? {bus.addr[11], bus.addr[9:0]} : bus.addr[10:0];
            gfx_wr.data   <= bus.wdata;
            psg1_wr       <= wr & sys_cs & (sub == sys_psg1);  // Data ignored
            psg2_wr       <= wr & sys_cs & (sub == sys_psg2);
            if (wr && sys_cs && sub == sys_ctrl) begin
                flip   <= bus.wdata[0];
                irq_en <= bus.wdata[2];
            end
            if (wr && region == region_color) pal_sel <= bus.wdata[2:0];
            if (wr && region == region_snd1) psg1_data <= bus.wdata;
            if (wr && region == region_snd2) psg2_data <= bus.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (rd) rd_data <= rd_mux;
    end

endmodule

//--- kicker_mixer.sv
`timescale 1ns/1ps

module kicker_mixer import kicker_pkg::*; #(
    parameter logic [7:0] gain0 = mix_gain0,   // 4.4 fixed point
    parameter logic [7:0] gain1 = mix_gain1
) (
    input  logic               clk,
    input  logic               rst,
    input  logic signed [10:0] ch0,
    input  logic signed [10:0] ch1,
    output logic signed [15:0] snd,
    output logic               peak
);
    logic signed [19:0] prod0;
    logic signed [19:0] prod1;
    logic signed [20:0] sum;
    logic signed [20:0] scaled;
    logic               over;
    logic               under;

    // Gains are unsigned, so pad a zero sign bit
    assign prod0  = ch0 * $signed({1'b0, gain0});
    assign prod1  = ch1 * $signed({1'b0, gain1});
    assign sum    = prod0 + prod1;
    assign scaled = sum >>> 4;     // Drop the fraction bits
    assign over   = scaled > 21'sd32767;
    assign under  = scaled < -21'sd32768;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            snd  <= 16'sd0;
            peak <= 1'b0;
        end else begin
            if (over) begin
                snd <= 16'sh7fff;
            end else if (under) begin
                snd <= -16'sh8000;
            end else begin
                snd <= scaled[15:0];
            end
            peak <= over | under;
        end
    end

endmodule

//--- psg_tone.sv
`timescale 1ns/1ps

module psg_tone import kicker_pkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               psg_cen,
    input  logic               wr,
    input  logic [7:0]         din,
    output logic signed [10:0] sound
);
    logic [2:0] reg_sel;   // Last latched register
    logic [9:0] period;
    logic [3:0] atten;
    logic [9:0] cnt;
    logic       phase;
    logic       flip_now;
    logic       phase_nx;
    logic [9:0] amp;

    // Period of zero behaves as one
    assign flip_now = cnt <= 10'd1;
    assign phase_nx = flip_now ? ~phase : phase;
    assign amp      = psg_atten_table[atten];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            reg_sel <= 3'd0;
            period  <= 10'd0;
            atten   <= 4'hf;       // Silent
        end else if (wr) begin
            if (din[7]) begin
                reg_sel <= din[6:4];
                case (din[6:4])
                    3'd0:    period[3:0] <= din[3:0];
                    3'd1:    atten       <= din[3:0];
                    default: ;
                endcase
            end else if (reg_sel == 3'd0) begin
                period[9:4] <= din[5:0];    // High bits of the tone period
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt   <= 10'd0;
            phase <= 1'b0;
            sound <= 11'sd0;
        end else if (psg_cen) begin
            cnt   <= flip_now ? period : cnt - 10'd1;
            phase <= phase_nx;
            // Output follows the new phase with the current attenuation
            if (phase_nx) begin
                sound <= $signed({1'b0, amp});
            end else begin
                sound <= -$signed({1'b0, amp});
            end
        end
    end

endmodule

//--- kicker_irq.sv
`timescale 1ns/1ps

module kicker_irq (
    input  logic clk,
    input  logic rst,
    input  logic lvbl,
    input  logic dip_pause,
    input  logic irq_en,
    output logic irq_n
);
    logic lvbl_l;
    logic vb_start;

    // Falling lvbl marks start of vertical blank
    assign vb_start = lvbl_l & ~lvbl;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            lvbl_l <= 1'b0;
            irq_n  <= 1'b1;
        end else begin
            lvbl_l <= lvbl;
            if (!irq_en) begin
                irq_n <= 1'b1;                  // Held off and cleared
            end else if (vb_start && dip_pause) begin
                irq_n <= 1'b0;                  // Pause low blocks new requests
            end
        end
    end

endmodule

//--- kicker_cabinet.sv
`timescale 1ns/1ps

module kicker_cabinet (
    input  logic [1:0] cab_sel,
    input  logic [1:0] start_button,
    input  logic [1:0] coin_input,
    input  logic [5:0] joystick1,
    input  logic [5:0] joystick2,
    input  logic       service,
    input  logic [3:0] dipsw_c,
    output logic [7:0] cabinet
);

    // Board wiring swaps up/down and left/right
    function automatic logic [7:0] joy_byte(input logic [5:0] joy);
        logic [7:0] b;
        b = {2'b11, joy[5:4], joy[2], joy[3], joy[0], joy[1]};
        return b;
    endfunction

    always_comb begin
        case (cab_sel)
            2'd0:    cabinet = {4'hf, dipsw_c};
            2'd1:    cabinet = joy_byte(joystick2);
            2'd2:    cabinet = joy_byte(joystick1);
            default: cabinet = {3'b111, start_button, service, coin_input};
        endcase
    end

endmodule

//--- kicker_pkg.sv
package kicker_pkg;

    // CPU side of the bus, one strobe per access
    typedef struct packed {
        logic        strobe;
        logic        we;     // High for a write
        logic [15:0] addr;
        logic [7:0]  wdata;
    } bus_req_t;

    // Write forwarded to the video block
    typedef struct packed {
        logic        strobe;
        logic        obj;    // Object RAM when high
        logic [10:0] addr;
        logic [7:0]  data;
    } gfx_wr_t;

    // Address bits 13..11
    localparam logic [2:0] region_sys    = 3'd0;
    localparam logic [2:0] region_snd2   = 3'd1;
    localparam logic [2:0] region_snd1   = 3'd2;
    localparam logic [2:0] region_color  = 3'd3;
    localparam logic [2:0] region_vscr   = 3'd4;
    localparam logic [2:0] region_obj_lo = 3'd5;
    localparam logic [2:0] region_obj_hi = 3'd6;
    localparam logic [2:0] region_vram   = 3'd7;

    // Address bits 10..8 inside the system region
    localparam logic [2:0] sys_ctrl   = 3'd0;
    localparam logic [2:0] sys_psg2   = 3'd3;
    localparam logic [2:0] sys_psg1   = 3'd4;
    localparam logic [2:0] sys_dip_b  = 3'd5;
    localparam logic [2:0] sys_dip_c  = 3'd6;
    localparam logic [2:0] sys_inputs = 3'd7;

    // Tone amplitude per attenuation step, 2 dB apart, last one is off
    localparam logic [9:0] psg_atten_table [16] = '{
        10'd1023, 10'd813, 10'd646, 10'd513,
        10'd407,  10'd324, 10'd257, 10'd204,
        10'd162,  10'd129, 10'd102, 10'd81,
        10'd65,   10'd51,  10'd41,  10'd0
    };

    // Mixer gains, 4.4 fixed point
    localparam logic [7:0] mix_gain0 = 8'h08;
    localparam logic [7:0] mix_gain1 = 8'h08;

endpackage
